/* design/am_lock_pkg.sv */
`default_nettype none

package am_lock_pkg;

  localparam int NB_BLOCK    = 66;  // sync header plus 64 payload bits
  localparam int NB_AM       = 48;  // marker bits without bip3 and bip7
  localparam int N_LANES_MAX = 20;  // markers defined for 100g

  // lock fsm states
  typedef enum logic [1:0] {
    LOCK_INIT,    // hunting for a first marker on any lane
    WAIT_SECOND,  // first marker seen, waiting one period
    LOCKED,       // marker position confirmed
    SLIP          // locked but counting missing markers
  } am_lock_state_t;

  // marker of one lane packed as m0 m1 m2 m4 m5 m6, big endian
  function automatic logic [NB_AM-1:0] am_lane_value(input int unsigned lane);
    case (lane)
      0:       return 48'hc168_213e_97de;
      1:       return 48'h9d71_8e62_8e71;
      2:       return 48'h594b_e8a6_b417;
      3:       return 48'h4d95_7bb2_6a84;
      4:       return 48'hf507_090a_f8f6;
      5:       return 48'hdd14_c222_eb3d;
      6:       return 48'h9a4a_2665_b5d9;
      7:       return 48'h7b45_6684_ba99;
      8:       return 48'ha024_765f_db89;
      9:       return 48'h68c9_fb97_3604;
      10:      return 48'hfd6c_9902_9366;
      11:      return 48'hb991_5546_6eaa;
      12:      return 48'h5cb9_b2a3_464d;
      13:      return 48'h1af8_bde5_0742;
      14:      return 48'h83c7_ca7c_3835;
      15:      return 48'h3536_cdca_c932;
      16:      return 48'hc431_4c3b_ceb3;
      17:      return 48'hadd6_b752_2948;
      18:      return 48'h5f66_2aa0_99d5;
      19:      return 48'hc0f0_e53f_0f1a;
      default: return '0;  // no marker beyond lane 19
    endcase
  endfunction

endpackage

`default_nettype wire

/* design/am_block_slicer.sv */
`timescale 1ns/1ns
`default_nettype none

module am_block_slicer
  import am_lock_pkg::*;
(
  input  logic                i_clock,
  input  logic                i_arst_n,
  input  logic                i_valid,     // one block per strobe
  input  logic [NB_BLOCK-1:0] i_block,     // sync header in the two msbs
  output logic                o_valid,
  output logic                o_sh_ok,     // control header seen
  output logic [NB_AM-1:0]    o_am_value   // marker bytes for the comparator
);

  localparam logic [1:0] SH_CTRL = 2'b10;  // control block header

  logic [1:0]       sync_header;
  logic [NB_AM-1:0] am_bits;

  assign sync_header = i_block[NB_BLOCK-1 -: 2];

  // byte map after the header is m0 m1 m2 bip3 m4 m5 m6 bip7
  assign am_bits = {i_block[63:40],   // m0 m1 m2
                    i_block[31:8]};   // m4 m5 m6

  // strobe follows the input one cycle late
  always_ff @(posedge i_clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
      o_valid <= 1'b0;
    else
      o_valid <= i_valid;
  end

  // payload only moves on accepted blocks
  always_ff @(posedge i_clock)
  begin
    if (i_valid)
    begin
      o_sh_ok    <= (sync_header == SH_CTRL);
      o_am_value <= am_bits;
    end
  end

endmodule

`default_nettype wire

/* design/am_lock_comparator.sv */
`timescale 1ns/1ns
`default_nettype none

module am_lock_comparator
  import am_lock_pkg::*;
#(
  parameter int N_ALIGNER = 20   // lanes searched
)
(
  input  logic                 i_enable_mask,   // fsm still hunting
  input  logic                 i_timer_done,    // marker expected now
  input  logic [NB_AM-1:0]     i_am_value,      // bits from the slicer
  input  logic [NB_AM-1:0]     i_compare_mask,  // cleared bits are don't care
  input  logic [N_ALIGNER-1:0] i_match_mask,    // lanes the fsm expects
  output logic                 o_am_match,
  output logic [N_ALIGNER-1:0] o_match_vector   // one bit per matching lane
);

  logic [N_ALIGNER-1:0] lane_hit;   // raw compare per lane
  logic                 any_hit;
  logic                 enable;

  // xnor per bit, masked bits forced to agree
  always_comb
  begin
    lane_hit = '0;
    for (int i = 0; i < N_ALIGNER; i++)
    begin
      lane_hit[i] = &(~(i_am_value ^ am_lane_value(i)) | ~i_compare_mask);
    end
  end

  assign o_match_vector = lane_hit & i_match_mask;  // only expected lanes
  assign any_hit        = |o_match_vector;
  assign enable         = i_enable_mask | i_timer_done;  // hunting or period end
  assign o_am_match     = any_hit & enable;

endmodule

`default_nettype wire

/* design/am_lock_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module am_lock_fsm
  import am_lock_pkg::*;
#(
  parameter int N_ALIGNER   = 20,
  parameter int AM_PERIOD   = 16384,   // valid blocks between markers
  parameter int MAX_INVALID = 4,       // misses before lock is lost
  parameter int NB_LANE_ID  = 5
)
(
  input  logic                  i_clock,
  input  logic                  i_arst_n,
  input  logic                  i_valid,         // registered block strobe
  input  logic                  i_sh_ok,
  input  logic                  i_am_match,
  input  logic [N_ALIGNER-1:0]  i_match_vector,
  output logic                  o_enable_mask,   // open compare while hunting
  output logic                  o_timer_done,
  output logic [N_ALIGNER-1:0]  o_match_mask,    // expected lane
  output logic                  o_am_lock,
  output logic [NB_LANE_ID-1:0] o_lane_id,
  output logic                  o_am_strobe      // one pulse per good marker
);

  localparam int NB_TIMER   = (AM_PERIOD > 1) ? $clog2(AM_PERIOD) : 1;
  localparam int NB_INVALID = $clog2(MAX_INVALID + 1);
  localparam logic [NB_TIMER-1:0]   TIMER_LOAD    = NB_TIMER'(AM_PERIOD - 1);
  localparam logic [NB_INVALID-1:0] INVALID_LIMIT = NB_INVALID'(MAX_INVALID);

  am_lock_state_t        state;
  logic [NB_TIMER-1:0]   timer;         // valid blocks left to next marker
  logic [NB_INVALID-1:0] invalid_cnt;   // consecutive missing markers
  logic [NB_INVALID-1:0] invalid_next;
  logic [N_ALIGNER-1:0]  match_mask;
  logic [NB_LANE_ID-1:0] lane_id;
  logic [NB_LANE_ID-1:0] lane_enc;
  logic                  am_lock;
  logic                  am_strobe;
  logic                  synced;
  logic                  timer_done;
  logic                  timer_load;
  logic                  marker_hit;    // good marker, slot gated by the comparator

  assign synced       = (state != LOCK_INIT);
  assign timer_done   = synced && i_valid && (timer == '0);
  assign marker_hit   = i_valid && i_sh_ok && i_am_match;
  assign timer_load   = marker_hit || timer_done;   // first marker or each marker slot
  assign invalid_next = invalid_cnt + 1'b1;

  // counts valid blocks only, gaps hold the count
  always_ff @(posedge i_clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
      timer <= '0;
    else if (timer_load)
      timer <= TIMER_LOAD;
    else if (i_valid && (timer != '0))
      timer <= timer - 1'b1;
  end

  // lowest matching lane wins when a loose mask hits several
  always_comb
  begin
    lane_enc = '0;
    for (int i = N_ALIGNER - 1; i >= 0; i--)
    begin
      if (i_match_vector[i])
        lane_enc = NB_LANE_ID'(i);
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      state       <= LOCK_INIT;
      match_mask  <= '1;             // all lanes searched
      lane_id     <= '0;
      invalid_cnt <= '0;
      am_lock     <= 1'b0;
      am_strobe   <= 1'b0;
    end
    else
    begin
      am_strobe <= 1'b0;             // single cycle pulse
      case (state)
        LOCK_INIT:
        begin
          if (marker_hit)
          begin
            match_mask <= i_match_vector;   // narrow search to this lane
            lane_id    <= lane_enc;
            state      <= WAIT_SECOND;
          end
        end
        WAIT_SECOND:
        begin
          if (marker_hit)
          begin
            am_lock     <= 1'b1;     // second marker one period later
            invalid_cnt <= '0;
            state       <= LOCKED;
          end
          else if (timer_done)
          begin
            match_mask <= '1;        // wrong or missing, hunt again
            lane_id    <= '0;
            state      <= LOCK_INIT;
          end
        end
        LOCKED, SLIP:
        begin
          if (marker_hit)
          begin
            invalid_cnt <= '0;
            am_strobe   <= 1'b1;
            state       <= LOCKED;
          end
          else if (timer_done)
          begin
            if (invalid_next == INVALID_LIMIT)
            begin
              am_lock     <= 1'b0;   // too many misses in a row
              match_mask  <= '1;
              lane_id     <= '0;
              invalid_cnt <= '0;
              state       <= LOCK_INIT;
            end
            else
            begin
              invalid_cnt <= invalid_next;
              state       <= SLIP;
            end
          end
        end
        default:
          state <= LOCK_INIT;
      endcase
    end
  end

  assign o_enable_mask = (state == LOCK_INIT);
  assign o_timer_done  = timer_done;
  assign o_match_mask  = match_mask;
  assign o_am_lock     = am_lock;
  assign o_lane_id     = lane_id;
  assign o_am_strobe   = am_strobe;

endmodule

`default_nettype wire

/* design/am_lock_top.sv */
`timescale 1ns/1ns
`default_nettype none

module am_lock_top
  import am_lock_pkg::*;
#(
  parameter int N_ALIGNER   = N_LANES_MAX,  // lanes searched
  parameter int AM_PERIOD   = 16384,        // blocks per marker period
  parameter int MAX_INVALID = 4,
  parameter int NB_LANE_ID  = 5
)
(
  input  logic                  i_clock,
  input  logic                  i_arst_n,
  input  logic                  i_valid,
  input  logic [NB_BLOCK-1:0]   i_block,
  input  logic [NB_AM-1:0]      i_compare_mask,  // static from config
  output logic                  o_am_lock,
  output logic [NB_LANE_ID-1:0] o_lane_id,
  output logic                  o_am_strobe
);

  logic                 blk_valid;
  logic                 blk_sh_ok;
  logic [NB_AM-1:0]     blk_am_value;
  logic                 enable_mask;
  logic                 timer_done;
  logic [N_ALIGNER-1:0] match_mask;
  logic                 am_match;
  logic [N_ALIGNER-1:0] match_vector;

  am_block_slicer u_slicer (
    .i_clock    (i_clock),
    .i_arst_n   (i_arst_n),
    .i_valid    (i_valid),
    .i_block    (i_block),
    .o_valid    (blk_valid),
    .o_sh_ok    (blk_sh_ok),
    .o_am_value (blk_am_value)
  );

  am_lock_comparator #(
    .N_ALIGNER (N_ALIGNER)
  ) u_comparator (
    .i_enable_mask  (enable_mask),
    .i_timer_done   (timer_done),
    .i_am_value     (blk_am_value),
    .i_compare_mask (i_compare_mask),
    .i_match_mask   (match_mask),
    .o_am_match     (am_match),
    .o_match_vector (match_vector)
  );

  am_lock_fsm #(
    .N_ALIGNER   (N_ALIGNER),
    .AM_PERIOD   (AM_PERIOD),
    .MAX_INVALID (MAX_INVALID),
    .NB_LANE_ID  (NB_LANE_ID)
  ) u_fsm (
    .i_clock        (i_clock),
    .i_arst_n       (i_arst_n),
    .i_valid        (blk_valid),
    .i_sh_ok        (blk_sh_ok),
    .i_am_match     (am_match),
    .i_match_vector (match_vector),
    .o_enable_mask  (enable_mask),
    .o_timer_done   (timer_done),
    .o_match_mask   (match_mask),
    .o_am_lock      (o_am_lock),
    .o_lane_id      (o_lane_id),
    .o_am_strobe    (o_am_strobe)
  );

endmodule

`default_nettype wire

/* test/am_lock_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module am_lock_tb
  import am_lock_pkg::*;
();

  localparam int AM_PERIOD      = 16;   // short period for simulation
  localparam int MAX_INVALID    = 4;
  localparam int N_ALIGNER      = 20;
  localparam int NB_LANE_ID     = 5;
  localparam int RESET_TIMEOUT  = 64;   // cycles
  localparam int STROBE_TIMEOUT = 8;
  localparam logic [NB_AM-1:0] MASK_FULL   = '1;
  localparam logic [NB_AM-1:0] MASK_NO_LOW = 48'hffff_ffff_ff00;  // m6 is don't care

  logic                  i_clock;
  logic                  i_arst_n;
  logic                  i_valid;
  logic [NB_BLOCK-1:0]   i_block;
  logic [NB_AM-1:0]      i_compare_mask;
  logic                  o_am_lock;
  logic [NB_LANE_ID-1:0] o_lane_id;
  logic                  o_am_strobe;

  logic [31:0]           lcg_state;   // data payload generator
  logic [NB_AM-1:0]      cur_mask;    // mask that goes out with the next block

  am_lock_top #(
    .N_ALIGNER   (N_ALIGNER),
    .AM_PERIOD   (AM_PERIOD),
    .MAX_INVALID (MAX_INVALID),
    .NB_LANE_ID  (NB_LANE_ID)
  ) dut_i (
    .i_clock        (i_clock),
    .i_arst_n       (i_arst_n),
    .i_valid        (i_valid),
    .i_block        (i_block),
    .i_compare_mask (i_compare_mask),
    .o_am_lock      (o_am_lock),
    .o_lane_id      (o_lane_id),
    .o_am_strobe    (o_am_strobe)
  );

  always #5 i_clock = ~i_clock;   // 10 ns period

  initial
  begin
    i_arst_n = 1'b0;
    repeat (16) @(posedge i_clock);
    i_arst_n <= 1'b1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // m0 m1 m2 bip3 m4 m5 m6 bip7 behind the sync header
  function automatic logic [NB_BLOCK-1:0] marker_block(input int unsigned lane,
                                                       input logic [1:0] sh,
                                                       input logic corrupt);
    logic [NB_AM-1:0] am;
    am = am_lane_value(lane);
    if (corrupt)
      am[7:0] = ~am[7:0];   // m6 flipped
    return {sh, am[47:24], 8'h3c, am[23:0], 8'hc3};   // bip bytes are junk
  endfunction

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // single bit status outputs
  task automatic check_lock(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR: t=%0t ns %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_lane(input logic [NB_LANE_ID-1:0] got,
                            input logic [NB_LANE_ID-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR: t=%0t ns o_lane_id got %0d expected %0d", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic feed_block(input logic [NB_BLOCK-1:0] blk);
    @(posedge i_clock);
    i_valid        <= 1'b1;
    i_block        <= blk;
    i_compare_mask <= cur_mask;
  endtask

  task automatic idle_cycle();
    @(posedge i_clock);
    i_valid <= 1'b0;   // gap, everything holds
  endtask

  // filler between markers, data header 01
  task automatic feed_data_run();
    logic [63:0] payload;
    for (int i = 0; i < AM_PERIOD - 1; i++)
    begin
      lcg_state      = lcg_next(lcg_state);
      payload[63:32] = lcg_state;
      lcg_state      = lcg_next(lcg_state);
      payload[31:0]  = lcg_state;
      feed_block({2'b01, payload});
    end
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (i_arst_n !== 1'b1)
    begin
      if (cycles == RESET_TIMEOUT)
      begin
        $display("timeout waiting for the end of reset");
        abort_run();
      end
      cycles++;
      @(posedge i_clock);
    end
  endtask

  // returns on the falling edge where the pulse is seen
  task automatic wait_strobe(output int cycles);
    cycles = 0;
    @(negedge i_clock);
    while (o_am_strobe !== 1'b1)
    begin
      if (cycles == STROBE_TIMEOUT)
      begin
        $display("timeout waiting for o_am_strobe after a marker");
        abort_run();
      end
      cycles++;
      @(negedge i_clock);
    end
  endtask

  // last block went out on edge n, fsm reflects it after edge n+2
  task automatic settle_and_check(input logic exp_lock,
                                  input logic [NB_LANE_ID-1:0] exp_lane,
                                  input logic exp_strobe);
    int strobe_cycles;
    idle_cycle();   // edge n+1, block sits in the slicer
    if (exp_strobe)
    begin
      wait_strobe(strobe_cycles);
      if (strobe_cycles != 1)
      begin
        $display("ERROR: t=%0t ns o_am_strobe delay got %0d cycles expected 2",
                 $time, strobe_cycles + 1);
        abort_run();
      end
      check_lock("o_am_lock", o_am_lock, exp_lock);
      check_lane(o_lane_id, exp_lane);
      @(negedge i_clock);
      check_lock("o_am_strobe", o_am_strobe, 1'b0);   // one cycle only
    end
    else
    begin
      @(posedge i_clock);   // edge n+2
      @(negedge i_clock);
      check_lock("o_am_lock", o_am_lock, exp_lock);
      check_lane(o_lane_id, exp_lane);
      check_lock("o_am_strobe", o_am_strobe, 1'b0);
    end
  endtask

  initial
  begin
    int          fd;
    int          n;
    int          lane;
    int          mode;
    int          lock_val;
    int          lane_val;
    int          lines;
    logic [7:0]  kind;
    logic [2047:0] rest;
    logic        prev_lock;
    logic        hit;
    logic        exp_strobe;

    i_clock        = 1'b0;
    i_valid        = 1'b0;
    i_block        = '0;
    i_compare_mask = MASK_FULL;
    cur_mask       = MASK_FULL;
    lcg_state      = 32'hca26_2873;
    prev_lock      = 1'b0;
    lines          = 0;

    fd = $fopen("test/am_lock_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("could not open test/am_lock_vectors.txt");
      abort_run();
    end

    wait_reset();
    @(negedge i_clock);
    check_lock("o_am_lock", o_am_lock, 1'b0);   // reset values
    check_lane(o_lane_id, '0);
    check_lock("o_am_strobe", o_am_strobe, 1'b0);

    while (!$feof(fd))
    begin
      n = $fscanf(fd, "%s", kind);
      if (n != 1)
        break;
      if (kind == "#")
      begin
        n = $fgets(rest, fd);   // column notes
        continue;
      end
      n = $fscanf(fd, "%d %d %d %d", lane, mode, lock_val, lane_val);
      if (n != 4)
      begin
        $display("malformed line in the vectors file after %0d lines", lines);
        abort_run();
      end
      cur_mask   = (mode != 0) ? MASK_NO_LOW : MASK_FULL;
      hit        = (kind == "M") || ((kind == "C") && (mode != 0));   // marker accepted
      exp_strobe = prev_lock && (lock_val != 0) && hit;
      case (kind)
        "M": feed_block(marker_block(lane, 2'b10, 1'b0));
        "C": feed_block(marker_block(lane, 2'b10, 1'b1));
        "S": feed_block(marker_block(lane, 2'b01, 1'b0));   // marker bits, data header
        "D": feed_data_run();
        "G": idle_cycle();
        default:
        begin
          $display("unknown stimulus kind in the vectors file");
          abort_run();
        end
      endcase
      settle_and_check(lock_val != 0, NB_LANE_ID'(lane_val), exp_strobe);
      prev_lock = (lock_val != 0);
      lines++;
    end
    $fclose(fd);

    if (lines == 0)
    begin
      $display("the vectors file held no stimulus lines");
      abort_run();
    end
    else
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* am_lock_top.f */
design/am_lock_pkg.sv
design/am_block_slicer.sv
design/am_lock_comparator.sv
design/am_lock_fsm.sv
design/am_lock_top.sv
test/am_lock_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the am_lock testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f am_lock_top.f --top-module am_lock_tb -o am_lock_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/am_lock_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF '*** TEST PASSED ***'; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi

/* test/am_lock_vectors.txt */
# kind lane mask lock lane_id   M marker, C marker low byte flipped, S marker with data header
# D AM_PERIOD-1 data blocks, G one idle cycle   mask 0 full compare, 1 low byte ignored
M 7 0 0 7
D 0 0 0 7
M 7 0 1 7
G 0 0 1 7
D 0 0 1 7
G 0 0 1 7
M 7 0 1 7
D 0 0 1 7
C 7 0 1 7
D 0 0 1 7
C 7 0 1 7
D 0 0 1 7
C 7 0 1 7
D 0 0 1 7
M 7 0 1 7
D 0 0 1 7
C 7 0 1 7
D 0 0 1 7
C 7 0 1 7
D 0 0 1 7
C 7 0 1 7
D 0 0 1 7
C 7 0 0 0
S 7 0 0 0
D 0 0 0 0
M 7 0 0 7
D 0 0 0 7
M 3 0 0 0
M 3 0 0 3
D 0 0 0 3
C 12 0 0 0
C 12 0 0 0
C 12 1 0 12
D 0 1 0 12
C 12 1 1 12
D 0 1 1 12
C 12 1 1 12
